//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= dcache_tb
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
design/dcache_pkg.sv
design/mem_bus_pkg.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_writeback_buf.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

//--- design/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter logic [7:0] lfsr_seed = 8'hb5
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  dcache_pkg::cpu_req_t                         cpu_req,
    output logic                                         cpu_ready,
    output dcache_pkg::cpu_resp_t                        cpu_resp,
    output mem_bus_pkg::mem_rd_req_t                     mem_rd_req,
    input  mem_bus_pkg::mem_rd_resp_t                    mem_rd_resp,
    output dcache_pkg::index_t                           arr_index,
    input  dcache_pkg::tag_t [dcache_pkg::num_ways-1:0]  tag_rd,
    input  logic [dcache_pkg::num_ways-1:0]              valid_rd,
    input  logic [dcache_pkg::num_ways-1:0]              dirty_rd,
    output logic [dcache_pkg::num_ways-1:0]              tag_we,
    output dcache_pkg::tag_t                             tag_wdata,
    output logic                                         dirty_wdata,
    input  dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_rd,
    output logic [dcache_pkg::num_ways-1:0]              line_we,
    output logic [dcache_pkg::num_ways-1:0][3:0]         word_we,
    output dcache_pkg::word_sel_t                        word_sel,
    output logic [31:0]                                  word_wdata,
    output dcache_pkg::line_t                            line_wdata,
    output logic                                         wb_load,
    output logic [31:0]                                  wb_addr,
    output dcache_pkg::line_t                            wb_line,
    input  logic                                         wb_busy,
    input  logic [31:0]                                  wb_pending_addr
);

    localparam int ow = dcache_pkg::offset_width;

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::ctrl_state_e state_nxt;

    dcache_pkg::cpu_req_t  req_q;
    dcache_pkg::tag_t      req_tag;
    dcache_pkg::index_t    req_index;
    dcache_pkg::word_sel_t req_word;

    logic [dcache_pkg::num_ways-1:0] hit_vec;
    logic                  hit;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::way_t      victim;
    dcache_pkg::way_t      fill_way;
    logic                  victim_dirty;
    logic                  accept;
    logic                  miss_go;
    logic                  wb_ok;
    logic [7:0]            lfsr;
    logic                  rd_sent;
    dcache_pkg::word_sel_t beat_cnt;
    dcache_pkg::line_t     refill_line;
    dcache_pkg::line_t     merged_line;

    assign cpu_ready = (state == dcache_pkg::st_idle);
    assign accept    = cpu_req.valid && cpu_ready;

    assign req_tag   = dcache_pkg::addr_tag(req_q.addr);
    assign req_index = dcache_pkg::addr_index(req_q.addr);
    assign req_word  = dcache_pkg::addr_word(req_q.addr);

    // tag compare
    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            hit_vec[w] = valid_rd[w] && (tag_rd[w] == req_tag);
        end
    end

    assign hit     = |hit_vec;
    assign hit_way = dcache_pkg::way_t'(hit_vec[1]);

    // empty way first, otherwise random
    always_comb begin
        if (!valid_rd[0]) begin
            victim = dcache_pkg::way_t'(0);
        end else if (!valid_rd[1]) begin
            victim = dcache_pkg::way_t'(1);
        end else begin
            victim = dcache_pkg::way_t'(lfsr[0]);
        end
    end

    assign victim_dirty = valid_rd[victim] && dirty_rd[victim];
    assign miss_go = (state == dcache_pkg::st_lookup) && !hit && !(victim_dirty && wb_busy);

    assign wb_load = miss_go && victim_dirty;
    assign wb_addr = {tag_rd[victim], req_index, {ow{1'b0}}};
    assign wb_line = line_rd[victim];

    // don't refetch a line still waiting in the writeback buffer
    assign wb_ok = !wb_busy || (wb_pending_addr[31:ow] != req_q.addr[31:ow]);

    assign mem_rd_req.valid = (state == dcache_pkg::st_refill) && !rd_sent && wb_ok;
    assign mem_rd_req.addr  = {req_q.addr[31:ow], {ow{1'b0}}};

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::st_idle: begin
                if (accept) begin
                    state_nxt = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_lookup: begin
                if (hit) begin
                    state_nxt = dcache_pkg::st_idle;
                end else if (miss_go) begin
                    state_nxt = dcache_pkg::st_refill;
                end
            end
            dcache_pkg::st_refill: begin
                if (mem_rd_resp.beat_valid && beat_cnt == dcache_pkg::word_sel_t'(3)) begin
                    state_nxt = dcache_pkg::st_install;
                end
            end
            default: state_nxt = dcache_pkg::st_idle;  // install
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= dcache_pkg::st_idle;
            lfsr     <= lfsr_seed;
            rd_sent  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (miss_go) begin
                rd_sent  <= 1'b0;
                beat_cnt <= '0;
            end else if (state == dcache_pkg::st_refill) begin
                if (mem_rd_req.valid && mem_rd_resp.accept) begin
                    rd_sent <= 1'b1;
                end
                if (mem_rd_resp.beat_valid) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        if (miss_go) begin
            fill_way <= victim;
        end
        if (state == dcache_pkg::st_refill && mem_rd_resp.beat_valid) begin
            refill_line[beat_cnt*32 +: 32] <= mem_rd_resp.data;
        end
    end

    // pending store over the fetched line
    always_comb begin
        merged_line = refill_line;
        if (req_q.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.be[b]) begin
                    merged_line[req_word*32 + b*8 +: 8] = req_q.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        if (state == dcache_pkg::st_idle) begin
            arr_index = dcache_pkg::addr_index(cpu_req.addr);
        end else begin
            arr_index = req_index;
        end
        tag_we      = '0;
        line_we     = '0;
        word_we     = '0;
        tag_wdata   = req_tag;
        dirty_wdata = req_q.write;  // set on store, clean on load fill
        word_sel    = req_word;
        word_wdata  = req_q.wdata;
        line_wdata  = merged_line;
        if (state == dcache_pkg::st_lookup && hit && req_q.write) begin
            tag_we[hit_way]  = 1'b1;
            word_we[hit_way] = req_q.be;
        end
        if (state == dcache_pkg::st_install) begin
            tag_we[fill_way]  = 1'b1;
            line_we[fill_way] = 1'b1;
        end
    end

    assign cpu_resp.valid = (state == dcache_pkg::st_lookup && hit)
                          || (state == dcache_pkg::st_install);
    assign cpu_resp.data  = (state == dcache_pkg::st_install) ? refill_line[req_word*32 +: 32]
                                                              : line_rd[hit_way][req_word*32 +: 32];

endmodule

//--- design/dcache_data_array.sv
`timescale 1ns/100ps

module dcache_data_array (
    input  logic                                         clk,
    input  dcache_pkg::index_t                           index,
    input  logic [dcache_pkg::num_ways-1:0]              line_we,
    input  logic [dcache_pkg::num_ways-1:0][3:0]         word_we,
    input  dcache_pkg::word_sel_t                        word_sel,
    input  logic [31:0]                                  word_wdata,
    input  dcache_pkg::line_t                            line_wdata,
    output dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_rd
);

    dcache_pkg::line_t line_mem [dcache_pkg::num_ways][dcache_pkg::num_sets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (line_we[w]) begin
                line_mem[w][index] <= line_wdata;  // refill install
            end else begin
                // store hit, byte lanes of one word
                for (int b = 0; b < 4; b++) begin
                    if (word_we[w][b]) begin
                        line_mem[w][index][word_sel*32 + b*8 +: 8] <= word_wdata[b*8 +: 8];
                    end
                end
            end
            line_rd[w] <= line_mem[w][index];
        end
    end

endmodule

//--- design/dcache_pkg.sv
package dcache_pkg;

    // 8 KB, 2 ways, 256 sets of 16-byte lines
    localparam int offset_width   = 4;
    localparam int index_width    = 8;
    localparam int tag_width      = 32 - index_width - offset_width;
    localparam int words_per_line = 4;
    localparam int num_ways       = 2;
    localparam int num_sets       = 1 << index_width;
    localparam int line_width     = 32 * words_per_line;

    typedef logic [tag_width-1:0]               tag_t;
    typedef logic [index_width-1:0]             index_t;
    typedef logic [$clog2(words_per_line)-1:0]  word_sel_t;
    typedef logic [$clog2(num_ways)-1:0]        way_t;
    typedef logic [line_width-1:0]              line_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } cpu_resp_t;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_install
    } ctrl_state_e;

    // address fields
    function automatic tag_t addr_tag(input logic [31:0] addr);
        return addr[31 -: tag_width];
    endfunction

    function automatic index_t addr_index(input logic [31:0] addr);
        return addr[offset_width +: index_width];
    endfunction

    function automatic word_sel_t addr_word(input logic [31:0] addr);
        return addr[2 +: $clog2(words_per_line)];
    endfunction

endpackage

//--- design/dcache_tag_array.sv
`timescale 1ns/100ps

module dcache_tag_array (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  dcache_pkg::index_t                        index,
    input  logic [dcache_pkg::num_ways-1:0]           tag_we,
    input  dcache_pkg::tag_t                          tag_wdata,
    input  logic                                      dirty_wdata,
    output dcache_pkg::tag_t [dcache_pkg::num_ways-1:0] tag_rd,
    output logic [dcache_pkg::num_ways-1:0]           valid_rd,
    output logic [dcache_pkg::num_ways-1:0]           dirty_rd
);

    dcache_pkg::tag_t tag_mem [dcache_pkg::num_ways][dcache_pkg::num_sets];

    logic [dcache_pkg::num_ways-1:0] valid_tbl [dcache_pkg::num_sets];
    logic [dcache_pkg::num_ways-1:0] dirty_tbl [dcache_pkg::num_sets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][index] <= tag_wdata;
            end
            tag_rd[w] <= tag_mem[w][index];  // old value on a write
        end
    end

    // valid and dirty bits per set, one bit per way
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < dcache_pkg::num_sets; s++) begin
                valid_tbl[s] <= '0;
                dirty_tbl[s] <= '0;
            end
            valid_rd <= '0;
            dirty_rd <= '0;
        end else begin
            for (int w = 0; w < dcache_pkg::num_ways; w++) begin
                if (tag_we[w]) begin
                    valid_tbl[index][w] <= 1'b1;
                    dirty_tbl[index][w] <= dirty_wdata;  // also the store-hit update
                end
            end
            valid_rd <= valid_tbl[index];
            dirty_rd <= dirty_tbl[index];
        end
    end

endmodule

//--- design/dcache_top.sv
`timescale 1ns/100ps

module dcache_top #(
    parameter logic [7:0] lfsr_seed = 8'hb5
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  dcache_pkg::cpu_req_t       cpu_req,
    output logic                       cpu_ready,
    output dcache_pkg::cpu_resp_t      cpu_resp,
    output mem_bus_pkg::mem_rd_req_t   mem_rd_req,
    input  mem_bus_pkg::mem_rd_resp_t  mem_rd_resp,
    output mem_bus_pkg::mem_wr_req_t   mem_wr_req,
    input  logic                       mem_wr_ack
);

    dcache_pkg::index_t                           arr_index;
    dcache_pkg::tag_t [dcache_pkg::num_ways-1:0]  tag_rd;
    logic [dcache_pkg::num_ways-1:0]              valid_rd;
    logic [dcache_pkg::num_ways-1:0]              dirty_rd;
    logic [dcache_pkg::num_ways-1:0]              tag_we;
    dcache_pkg::tag_t                             tag_wdata;
    logic                                         dirty_wdata;
    dcache_pkg::line_t [dcache_pkg::num_ways-1:0] line_rd;
    logic [dcache_pkg::num_ways-1:0]              line_we;
    logic [dcache_pkg::num_ways-1:0][3:0]         word_we;
    dcache_pkg::word_sel_t                        word_sel;
    logic [31:0]                                  word_wdata;
    dcache_pkg::line_t                            line_wdata;
    logic                                         wb_load;
    logic [31:0]                                  wb_addr;
    dcache_pkg::line_t                            wb_line;
    logic                                         wb_busy;
    logic [31:0]                                  wb_pending_addr;

    dcache_ctrl #(
        .lfsr_seed (lfsr_seed)
    ) ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_req         (cpu_req),
        .cpu_ready       (cpu_ready),
        .cpu_resp        (cpu_resp),
        .mem_rd_req      (mem_rd_req),
        .mem_rd_resp     (mem_rd_resp),
        .arr_index       (arr_index),
        .tag_rd          (tag_rd),
        .valid_rd        (valid_rd),
        .dirty_rd        (dirty_rd),
        .tag_we          (tag_we),
        .tag_wdata       (tag_wdata),
        .dirty_wdata     (dirty_wdata),
        .line_rd         (line_rd),
        .line_we         (line_we),
        .word_we         (word_we),
        .word_sel        (word_sel),
        .word_wdata      (word_wdata),
        .line_wdata      (line_wdata),
        .wb_load         (wb_load),
        .wb_addr         (wb_addr),
        .wb_line         (wb_line),
        .wb_busy         (wb_busy),
        .wb_pending_addr (wb_pending_addr)
    );

    dcache_tag_array tag_array_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (arr_index),
        .tag_we      (tag_we),
        .tag_wdata   (tag_wdata),
        .dirty_wdata (dirty_wdata),
        .tag_rd      (tag_rd),
        .valid_rd    (valid_rd),
        .dirty_rd    (dirty_rd)
    );

    dcache_data_array data_array_i (
        .clk        (clk),
        .index      (arr_index),
        .line_we    (line_we),
        .word_we    (word_we),
        .word_sel   (word_sel),
        .word_wdata (word_wdata),
        .line_wdata (line_wdata),
        .line_rd    (line_rd)
    );

    dcache_writeback_buf wb_buf_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_load         (wb_load),
        .wb_addr         (wb_addr),
        .wb_line         (wb_line),
        .wb_busy         (wb_busy),
        .wb_pending_addr (wb_pending_addr),
        .mem_wr_req      (mem_wr_req),
        .mem_wr_ack      (mem_wr_ack)
    );

endmodule

//--- design/dcache_writeback_buf.sv
`timescale 1ns/100ps

module dcache_writeback_buf (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wb_load,
    input  logic [31:0]               wb_addr,
    input  dcache_pkg::line_t         wb_line,
    output logic                      wb_busy,
    output logic [31:0]               wb_pending_addr,
    output mem_bus_pkg::mem_wr_req_t  mem_wr_req,
    input  logic                      mem_wr_ack
);

    logic              busy;
    logic [31:0]       line_addr;
    dcache_pkg::line_t line_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (wb_load) begin
            busy <= 1'b1;  // controller loads only when free
        end else if (mem_wr_ack) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_load) begin
            line_addr <= wb_addr;
            line_data <= wb_line;
        end
    end

    assign wb_busy         = busy;
    assign wb_pending_addr = line_addr;

    // held stable until accepted
    assign mem_wr_req.valid = busy;
    assign mem_wr_req.addr  = line_addr;
    assign mem_wr_req.line  = line_data;

endmodule

//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

    // refill read, one line as four word beats
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;    // line aligned
    } mem_rd_req_t;

    typedef struct packed {
        logic        accept;  // address taken
        logic        beat_valid;
        logic [31:0] data;
    } mem_rd_resp_t;

    // whole-line writeback
    typedef struct packed {
        logic              valid;
        logic [31:0]       addr;
        dcache_pkg::line_t line;
    } mem_wr_req_t;

endpackage

//--- sim/dcache_checker.sv
`timescale 1ns/100ps

module dcache_checker (
    input logic                      clk,
    input logic                      rst_n,
    input dcache_pkg::cpu_req_t      cpu_req,
    input logic                      cpu_ready,
    input dcache_pkg::cpu_resp_t     cpu_resp,
    input mem_bus_pkg::mem_rd_req_t  mem_rd_req,
    input mem_bus_pkg::mem_rd_resp_t mem_rd_resp,
    input mem_bus_pkg::mem_wr_req_t  mem_wr_req,
    input logic                      mem_wr_ack
);

    logic        last_seen;  // a request was accepted since reset
    logic [27:0] last_line;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_seen <= 1'b0;
        end else if (cpu_req.valid && cpu_ready) begin
            last_seen <= 1'b1;
            last_line <= cpu_req.addr[31:4];
        end
    end

    // idle and quiet right after reset
    reset_state: assert property (@(posedge clk) !rst_n |=> cpu_ready && !cpu_resp.valid
                                  && !mem_rd_req.valid && !mem_wr_req.valid)
        else $error("outputs not idle after reset");

    // line of the previous request is still cached, so this one hits
    hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
                                 cpu_req.valid && cpu_ready && last_seen
                                 && cpu_req.addr[31:4] == last_line |=> cpu_resp.valid)
        else $error("access to the line just used did not respond in one cycle");

    resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                 cpu_resp.valid |=> !cpu_resp.valid && cpu_ready)
        else $error("response longer than one cycle");

    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
                              mem_rd_req.valid && !mem_rd_resp.accept
                              |=> mem_rd_req.valid && $stable(mem_rd_req.addr))
        else $error("read request dropped or changed before accept");

    // refill of the line in flight, line aligned
    rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
                              mem_rd_req.valid |-> mem_rd_req.addr == {last_line, 4'h0})
        else $error("read address is not the aligned line of the request");

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
                              mem_wr_req.valid && !mem_wr_ack |=> mem_wr_req.valid
                              && $stable(mem_wr_req.addr) && $stable(mem_wr_req.line))
        else $error("write request dropped or changed before accept");

endmodule

bind dcache_top dcache_checker checker_i (.*);

//--- sim/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    localparam int n_random = 300;
    localparam int n_requests = n_random + 16;

    logic clk = 1'b0;
    logic rst_n;
    dcache_pkg::cpu_req_t      cpu_req;
    logic                      cpu_ready;
    dcache_pkg::cpu_resp_t     cpu_resp;
    mem_bus_pkg::mem_rd_req_t  mem_rd_req;
    mem_bus_pkg::mem_rd_resp_t mem_rd_resp;
    mem_bus_pkg::mem_wr_req_t  mem_wr_req;
    logic                      mem_wr_ack;

    logic [31:0] backing [logic [29:0]];  // memory behind the cache
    logic [31:0] shadow [logic [29:0]];   // what the cpu should see
    int wb_count = 0;
    int lat;
    bit fail_shown = 1'b0;
    bit run_passed = 1'b0;

    dcache_top #(.lfsr_seed(8'h3c)) dcache_top_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a, input bit from_shadow);
        if (from_shadow) return shadow.exists(a[31:2]) ? shadow[a[31:2]] : fill_word(a);
        return backing.exists(a[31:2]) ? backing[a[31:2]] : fill_word(a);
    endfunction

    task automatic report_error(input string msg);
        fail_shown = 1'b1;
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic serve_reads();
        forever begin
            @(negedge clk);
            if (mem_rd_req.valid) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                mem_rd_resp.accept = 1'b1;
                @(negedge clk);
                mem_rd_resp.accept = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    repeat ($urandom_range(0, 2)) @(negedge clk);
                    mem_rd_resp.beat_valid = 1'b1;
                    mem_rd_resp.data = mem_word(mem_rd_req.addr + 4 * i, 1'b0);
                    @(negedge clk);
                    mem_rd_resp.beat_valid = 1'b0;
                end
            end
        end
    endtask

    task automatic serve_writes();
        dcache_pkg::line_t exp_line;
        forever begin
            @(negedge clk);
            if (mem_wr_req.valid) begin
                for (int i = 0; i < 4; i++) begin
                    exp_line[i*32 +: 32] = mem_word(mem_wr_req.addr + 4 * i, 1'b1);
                end
                assert (mem_wr_req.addr[3:0] == 4'h0 && mem_wr_req.line == exp_line)
                    else report_error($sformatf("writeback %h line %h",
                                                mem_wr_req.addr, mem_wr_req.line));
                repeat ($urandom_range(0, 4)) @(negedge clk);
                mem_wr_ack = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    backing[mem_wr_req.addr[31:2] + i] = mem_wr_req.line[i*32 +: 32];
                end
                wb_count++;
                @(negedge clk);
                mem_wr_ack = 1'b0;
            end
        end
    endtask

    task automatic cpu_access(input logic wr, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output int latency);
        logic [31:0] expected;
        logic [31:0] merged;
        @(negedge clk);
        cpu_req = '{valid: 1'b1, write: wr, be: be, addr: addr, wdata: wdata};
        while (!cpu_ready) @(negedge clk);
        expected = mem_word(addr, 1'b1);
        merged = expected;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) merged[b*8 +: 8] = wdata[b*8 +: 8];
        end
        if (wr) shadow[addr[31:2]] = merged;  // takes effect at acceptance
        @(negedge clk);
        cpu_req = '0;
        latency = 1;
        while (!cpu_resp.valid) begin
            @(negedge clk);
            latency++;
        end
        if (!wr) begin
            assert (cpu_resp.data == expected)
                else report_error($sformatf("read %h got %h expected %h",
                                            addr, cpu_resp.data, expected));
        end
    endtask

    initial begin
        repeat (200 * n_requests + 20) @(posedge clk);
        fail_shown = 1'b1;
        $display("timeout, the cache stopped responding");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    final begin
        if (!run_passed && !fail_shown) begin
            $display("TESTBENCH FAILED");
        end
    end

    initial begin
        int wb_before;
        void'($urandom(32'h974e_44d7));
        rst_n = 1'b0;
        cpu_req = '0;
        mem_rd_resp = '0;
        mem_wr_ack = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        fork
            serve_reads();
            serve_writes();
        join_none

        cpu_access(1'b0, 4'h0, 32'h0001_2344, 0, lat);  // read miss
        cpu_access(1'b0, 4'h0, 32'h0001_2344, 0, lat);
        assert (lat == 1) else report_error($sformatf("hit latency %0d", lat));
        wb_before = wb_count;
        cpu_access(1'b1, 4'b0101, 32'h0001_2344, 32'hdead_beef, lat);  // write hit
        cpu_access(1'b0, 4'h0, 32'h0001_2344, 0, lat);
        assert (wb_count == wb_before) else report_error("memory write on a write hit");
        cpu_access(1'b1, 4'b1100, 32'h0004_5508, 32'h1234_5678, lat);  // write miss
        cpu_access(1'b0, 4'h0, 32'h0004_5508, 0, lat);
        for (int t = 1; t <= 3; t++) cpu_access(1'b1, 4'hf, {20'(t), 8'h77, 4'h4}, $urandom, lat);
        for (int c = 0; c < 20 && wb_count == wb_before; c++) begin
            @(negedge clk);
        end
        assert (wb_count > wb_before) else report_error("no writeback after three tags");
        for (int t = 1; t <= 3; t++) cpu_access(1'b0, 4'h0, {20'(t), 8'h77, 4'h4}, 0, lat);

        for (int i = 0; i < n_random; i++) begin
            cpu_access(1'($urandom), 4'($urandom_range(1, 15)),
                       {20'h00a00 + 20'($urandom_range(0, 3)), 8'h40 + 8'($urandom_range(0, 2)),
                        2'($urandom), 2'b00}, $urandom, lat);
        end
        run_passed = 1'b1;
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
